/* arc_pkg.sv */
package arc_pkg;

	// bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int IDX_W  = 5;
	// i/o controller control port width
	localparam int CTRL_W = 6;

	// word address, byte address bits 25:2
	typedef logic [ADDR_W-1:0] cpu_addr_t;
	typedef logic [DATA_W-1:0] cpu_data_t;
	typedef logic [BYTE_W-1:0] ioc_byte_t;
	// register index, byte address bits 6:2
	typedef logic [IDX_W-1:0]  ioc_index_t;

	// region bounds as word addresses, byte values shifted down by two
	// ram below 32 MB
	localparam cpu_addr_t RAM_LIMIT   = cpu_addr_t'(26'h200_0000 >> 2);
	// rom, top of the 26-bit space
	localparam cpu_addr_t ROM_BASE    = cpu_addr_t'(26'h380_0000 >> 2);
	// one past the last word, so one bit wider than a word address
	localparam logic [ADDR_W:0] ROM_LIMIT = (ADDR_W + 1)'(27'h400_0000 >> 2);
	// i/o controller window
	localparam cpu_addr_t IOC_BASE    = cpu_addr_t'(26'h320_0000 >> 2);
	localparam cpu_addr_t IOC_LIMIT   = cpu_addr_t'(26'h330_0000 >> 2);
	// external latch a, floppy control and led
	localparam cpu_addr_t LATCHA_ADDR = cpu_addr_t'(26'h335_0040 >> 2);

	// reset value of latch a, led on
	localparam ioc_byte_t LATCHA_RESET = 8'hFF;

	// i/o controller register map
	localparam ioc_index_t IOC_CTRL     = 5'd0;
	localparam ioc_index_t IOC_KBD      = 5'd1;
	localparam ioc_index_t IOC_IRQ_STAT = 5'd4;
	localparam ioc_index_t IOC_IRQ_REQ  = 5'd5;
	localparam ioc_index_t IOC_IRQ_MASK = 5'd6;

	// interrupt bits in status, request and mask
	localparam int IRQ_FLYBACK      = 3;
	localparam int IRQ_KBD_TX_EMPTY = 6;
	localparam int IRQ_KBD_RX_FULL  = 7;

	// bus controller states
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_MEM_WAIT,
		BUS_REPLY
	} bus_state_e;

endpackage

/* arc_por.sv */
`timescale 1ns/1ns

module arc_por #(
	parameter int POR_CYCLES = 16
) (
	input  logic CLKCPU_I,
	input  logic rst_n_i,
	output logic sys_rst_n_o
);

	// wide enough to hold POR_CYCLES
	localparam int CNT_W = $clog2(POR_CYCLES + 1);

	// two stage release synchronizer
	logic [1:0]       sync_q;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge CLKCPU_I or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sync_q      <= '0;
			cnt         <= '0;
			sys_rst_n_o <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
			// count once the synchronized release is through
			if (sync_q[1] && !sys_rst_n_o) begin
				if (cnt == CNT_W'(POR_CYCLES - 1)) begin
					sys_rst_n_o <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// stretched reset only drops when the raw reset does
	a_no_spurious_reset: assert property (@(posedge CLKCPU_I)
		$fell(sys_rst_n_o) |-> !rst_n_i);

endmodule

/* arc_bus_ctrl.sv */
`timescale 1ns/1ns

module arc_bus_ctrl (
	input  logic                CLKCPU_I,
	input  logic                rst_n_i,
	// cpu side
	input  logic                cpu_cyc_i,
	input  logic                cpu_stb_i,
	input  logic                cpu_we_i,
	input  logic [3:0]          cpu_sel_i,
	input  arc_pkg::cpu_addr_t  cpu_adr_i,
	input  arc_pkg::cpu_data_t  cpu_dat_i,
	output arc_pkg::cpu_data_t  cpu_dat_o,
	output logic                cpu_ack_o,
	output logic                cpu_err_o,
	// memory side
	output logic                mem_cyc_o,
	output logic                mem_stb_o,
	output logic                mem_we_o,
	output logic [3:0]          mem_sel_o,
	output arc_pkg::cpu_addr_t  mem_adr_o,
	output arc_pkg::cpu_data_t  mem_dat_o,
	input  logic                mem_ack_i,
	input  arc_pkg::cpu_data_t  mem_dat_i,
	// i/o controller side
	output logic                ioc_sel_o,
	output logic                ioc_we_o,
	output arc_pkg::ioc_index_t ioc_idx_o,
	output arc_pkg::ioc_byte_t  ioc_wdata_o,
	input  arc_pkg::ioc_byte_t  ioc_rdata_i,
	// floppy led
	output logic                debug_led_o
);

	arc_pkg::bus_state_e state;

	// request captured on the accepting cycle
	arc_pkg::cpu_addr_t req_adr;
	arc_pkg::cpu_data_t req_dat;
	logic [3:0]         req_sel;
	logic               req_we;
	// target of the captured request
	logic               req_ioc;
	logic               req_latch;

	logic               mem_req;
	arc_pkg::ioc_byte_t latch_a;

	// decode of the incoming address
	logic                     start;
	logic                     hit_mem;
	logic                     hit_ioc;
	logic                     hit_latch;
	logic [arc_pkg::ADDR_W:0] adr_ext;
	arc_pkg::cpu_data_t       int_rdata;

	// a fresh strobe, not the tail of the one just answered
	assign start = (state == arc_pkg::BUS_IDLE) && cpu_cyc_i && cpu_stb_i &&
		!cpu_ack_o && !cpu_err_o;

	assign adr_ext   = {1'b0, cpu_adr_i};
	assign hit_mem   = (cpu_adr_i < arc_pkg::RAM_LIMIT) ||
		((cpu_adr_i >= arc_pkg::ROM_BASE) && (adr_ext < arc_pkg::ROM_LIMIT));
	assign hit_ioc   = (cpu_adr_i >= arc_pkg::IOC_BASE) && (cpu_adr_i < arc_pkg::IOC_LIMIT);
	assign hit_latch = (cpu_adr_i == arc_pkg::LATCHA_ADDR);

	// control fsm
	always_ff @(posedge CLKCPU_I or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state     <= arc_pkg::BUS_IDLE;
			cpu_ack_o <= 1'b0;
			cpu_err_o <= 1'b0;
			mem_req   <= 1'b0;
			req_ioc   <= 1'b0;
			req_latch <= 1'b0;
			latch_a   <= arc_pkg::LATCHA_RESET;
		end else begin
			// replies are one cycle pulses
			cpu_ack_o <= 1'b0;
			cpu_err_o <= 1'b0;
			case (state)
				arc_pkg::BUS_IDLE: begin
					if (start) begin
						req_ioc   <= hit_ioc;
						req_latch <= hit_latch;
						if (hit_mem) begin
							mem_req <= 1'b1;
							state   <= arc_pkg::BUS_MEM_WAIT;
						end else begin
							state <= arc_pkg::BUS_REPLY;
						end
					end
				end
				arc_pkg::BUS_MEM_WAIT: begin
					// memory may stall as long as it likes
					if (mem_ack_i) begin
						mem_req   <= 1'b0;
						cpu_ack_o <= 1'b1;
						state     <= arc_pkg::BUS_IDLE;
					end
				end
				arc_pkg::BUS_REPLY: begin
					// unmapped space gets an error
					if (req_ioc || req_latch) begin
						cpu_ack_o <= 1'b1;
					end else begin
						cpu_err_o <= 1'b1;
					end
					if (req_latch && req_we) begin
						latch_a <= req_dat[23:16];
					end
					state <= arc_pkg::BUS_IDLE;
				end
				default: state <= arc_pkg::BUS_IDLE;
			endcase
		end
	end

	// internal read data, ioc byte on every lane
	assign int_rdata = req_ioc ? {4{ioc_rdata_i}} :
		req_latch ? {24'h0, latch_a} : '0;

	// request and read data registers
	always_ff @(posedge CLKCPU_I) begin
		if (start) begin
			req_adr <= cpu_adr_i;
			req_dat <= cpu_dat_i;
			req_sel <= cpu_sel_i;
			req_we  <= cpu_we_i;
		end
		if ((state == arc_pkg::BUS_MEM_WAIT) && mem_ack_i) begin
			cpu_dat_o <= mem_dat_i;
		end else if (state == arc_pkg::BUS_REPLY) begin
			cpu_dat_o <= int_rdata;
		end
	end

	// memory port, straight from the captured request
	assign mem_cyc_o = mem_req;
	assign mem_stb_o = mem_req;
	assign mem_we_o  = req_we;
	assign mem_sel_o = req_sel;
	assign mem_adr_o = req_adr;
	assign mem_dat_o = req_dat;

	// ioc select lasts the single reply cycle
	assign ioc_sel_o   = (state == arc_pkg::BUS_REPLY) && req_ioc;
	assign ioc_we_o    = req_we;
	assign ioc_idx_o   = req_adr[arc_pkg::IDX_W-1:0];
	assign ioc_wdata_o = req_dat[23:16];

	// led off only when both drive select bits are low
	assign debug_led_o = latch_a[6] | latch_a[0];

	a_ack_err_excl: assert property (@(posedge CLKCPU_I) disable iff (!rst_n_i)
		!(cpu_ack_o && cpu_err_o));

	a_mem_stb_wait: assert property (@(posedge CLKCPU_I) disable iff (!rst_n_i)
		mem_stb_o |-> (state == arc_pkg::BUS_MEM_WAIT));

endmodule

/* arc_ioc.sv */
`timescale 1ns/1ns

module arc_ioc (
	input  logic                      CLKCPU_I,
	input  logic                      rst_n_i,
	// register access from the bus controller
	input  logic                      sel_i,
	input  logic                      we_i,
	input  arc_pkg::ioc_index_t       idx_i,
	input  arc_pkg::ioc_byte_t        wdata_i,
	output arc_pkg::ioc_byte_t        rdata_o,
	// control port
	output logic [arc_pkg::CTRL_W-1:0] ctrl_o,
	// video flyback
	input  logic                      flyback_i,
	// keyboard link
	output arc_pkg::ioc_byte_t        kbd_out_data_o,
	output logic                      kbd_out_strobe_o,
	input  arc_pkg::ioc_byte_t        kbd_in_data_i,
	input  logic                      kbd_in_strobe_i,
	// interrupt to the cpu
	output logic                      irq_o
);

	arc_pkg::ioc_byte_t rx_data;
	arc_pkg::ioc_byte_t irq_mask;
	arc_pkg::ioc_byte_t irq_stat;
	logic               rx_full;
	logic               tx_empty;
	logic               fly_stat;
	logic               flyback_q;

	// register strobes
	logic               wr_ctrl;
	logic               wr_kbd;
	logic               rd_kbd;
	logic               wr_req;
	logic               wr_mask;
	logic               fly_edge;

	assign wr_ctrl  = sel_i && we_i && (idx_i == arc_pkg::IOC_CTRL);
	assign wr_kbd   = sel_i && we_i && (idx_i == arc_pkg::IOC_KBD);
	assign rd_kbd   = sel_i && !we_i && (idx_i == arc_pkg::IOC_KBD);
	assign wr_req   = sel_i && we_i && (idx_i == arc_pkg::IOC_IRQ_REQ);
	assign wr_mask  = sel_i && we_i && (idx_i == arc_pkg::IOC_IRQ_MASK);
	assign fly_edge = flyback_i && !flyback_q;

	// raw status with unused bits reading zero
	always_comb begin
		irq_stat = '0;
		irq_stat[arc_pkg::IRQ_FLYBACK]      = fly_stat;
		irq_stat[arc_pkg::IRQ_KBD_TX_EMPTY] = tx_empty;
		irq_stat[arc_pkg::IRQ_KBD_RX_FULL]  = rx_full;
	end

	always_ff @(posedge CLKCPU_I or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_o           <= '1;
			irq_mask         <= '0;
			rx_full          <= 1'b0;
			tx_empty         <= 1'b1;
			fly_stat         <= 1'b0;
			flyback_q        <= 1'b0;
			kbd_out_strobe_o <= 1'b0;
			irq_o            <= 1'b0;
		end else begin
			flyback_q <= flyback_i;
			if (wr_ctrl) begin
				ctrl_o <= wdata_i[arc_pkg::CTRL_W-1:0];
			end
			if (wr_mask) begin
				irq_mask <= wdata_i;
			end
			// transmit strobe goes out the cycle after the write
			kbd_out_strobe_o <= wr_kbd;
			if (wr_kbd) begin
				tx_empty <= 1'b0;
			end else if (kbd_out_strobe_o) begin
				tx_empty <= 1'b1;
			end
			// new byte wins over a read in the same cycle
			if (kbd_in_strobe_i) begin
				rx_full <= 1'b1;
			end else if (rd_kbd) begin
				rx_full <= 1'b0;
			end
			// flyback set wins over a clear
			if (fly_edge) begin
				fly_stat <= 1'b1;
			end else if (wr_req && wdata_i[arc_pkg::IRQ_FLYBACK]) begin
				fly_stat <= 1'b0;
			end
			irq_o <= |(irq_stat & irq_mask);
		end
	end

	// keyboard data bytes
	always_ff @(posedge CLKCPU_I) begin
		if (wr_kbd) begin
			kbd_out_data_o <= wdata_i;
		end
		if (kbd_in_strobe_i) begin
			rx_data <= kbd_in_data_i;
		end
	end

	// register read mux
	always_comb begin
		case (idx_i)
			arc_pkg::IOC_CTRL:     rdata_o = {2'b00, ctrl_o};
			arc_pkg::IOC_KBD:      rdata_o = rx_data;
			arc_pkg::IOC_IRQ_STAT: rdata_o = irq_stat;
			arc_pkg::IOC_IRQ_REQ:  rdata_o = irq_stat & irq_mask;
			arc_pkg::IOC_IRQ_MASK: rdata_o = irq_mask;
			default:               rdata_o = '0;
		endcase
	end

	a_kbd_strobe_pulse: assert property (@(posedge CLKCPU_I) disable iff (!rst_n_i)
		kbd_out_strobe_o |=> !kbd_out_strobe_o);

endmodule

/* arc_io_top.sv */
`timescale 1ns/1ns

module arc_io_top #(
	parameter int POR_CYCLES = 16
) (
	input  logic                       CLKCPU_I,
	input  logic                       rst_n_i,
	// cpu bus
	input  logic                       cpu_cyc_i,
	input  logic                       cpu_stb_i,
	input  logic                       cpu_we_i,
	input  logic [3:0]                 cpu_sel_i,
	input  arc_pkg::cpu_addr_t         cpu_adr_i,
	input  arc_pkg::cpu_data_t         cpu_dat_i,
	output arc_pkg::cpu_data_t         cpu_dat_o,
	output logic                       cpu_ack_o,
	output logic                       cpu_err_o,
	output logic                       cpu_irq_o,
	// external memory
	output logic                       mem_cyc_o,
	output logic                       mem_stb_o,
	output logic                       mem_we_o,
	output logic [3:0]                 mem_sel_o,
	output arc_pkg::cpu_addr_t         mem_adr_o,
	output arc_pkg::cpu_data_t         mem_dat_o,
	input  logic                       mem_ack_i,
	input  arc_pkg::cpu_data_t         mem_dat_i,
	// video flyback and keyboard
	input  logic                       flyback_i,
	output arc_pkg::ioc_byte_t         kbd_out_data_o,
	output logic                       kbd_out_strobe_o,
	input  arc_pkg::ioc_byte_t         kbd_in_data_i,
	input  logic                       kbd_in_strobe_i,
	// control port and floppy led
	output logic [arc_pkg::CTRL_W-1:0] ioc_ctrl_o,
	output logic                       debug_led_o
);

	// stretched reset for the whole subsystem
	logic                sys_rst_n;
	// bus controller to ioc
	logic                ioc_sel;
	logic                ioc_we;
	arc_pkg::ioc_index_t ioc_idx;
	arc_pkg::ioc_byte_t  ioc_wdata;
	arc_pkg::ioc_byte_t  ioc_rdata;

	arc_por #(
		.POR_CYCLES(POR_CYCLES)
	) por_i (
		.CLKCPU_I    (CLKCPU_I),
		.rst_n_i     (rst_n_i),
		.sys_rst_n_o (sys_rst_n)
	);

	arc_bus_ctrl bus_i (
		.CLKCPU_I    (CLKCPU_I),
		.rst_n_i     (sys_rst_n),
		.cpu_cyc_i   (cpu_cyc_i),
		.cpu_stb_i   (cpu_stb_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_sel_i   (cpu_sel_i),
		.cpu_adr_i   (cpu_adr_i),
		.cpu_dat_i   (cpu_dat_i),
		.cpu_dat_o   (cpu_dat_o),
		.cpu_ack_o   (cpu_ack_o),
		.cpu_err_o   (cpu_err_o),
		.mem_cyc_o   (mem_cyc_o),
		.mem_stb_o   (mem_stb_o),
		.mem_we_o    (mem_we_o),
		.mem_sel_o   (mem_sel_o),
		.mem_adr_o   (mem_adr_o),
		.mem_dat_o   (mem_dat_o),
		.mem_ack_i   (mem_ack_i),
		.mem_dat_i   (mem_dat_i),
		.ioc_sel_o   (ioc_sel),
		.ioc_we_o    (ioc_we),
		.ioc_idx_o   (ioc_idx),
		.ioc_wdata_o (ioc_wdata),
		.ioc_rdata_i (ioc_rdata),
		.debug_led_o (debug_led_o)
	);

	arc_ioc ioc_i (
		.CLKCPU_I         (CLKCPU_I),
		.rst_n_i          (sys_rst_n),
		.sel_i            (ioc_sel),
		.we_i             (ioc_we),
		.idx_i            (ioc_idx),
		.wdata_i          (ioc_wdata),
		.rdata_o          (ioc_rdata),
		.ctrl_o           (ioc_ctrl_o),
		.flyback_i        (flyback_i),
		.kbd_out_data_o   (kbd_out_data_o),
		.kbd_out_strobe_o (kbd_out_strobe_o),
		.kbd_in_data_i    (kbd_in_data_i),
		.kbd_in_strobe_i  (kbd_in_strobe_i),
		.irq_o            (cpu_irq_o)
	);

endmodule

/* tb_arc_checker.sv */
`timescale 1ns/1ns

module tb_arc_checker (
	input  logic                CLKCPU_I,
	input  logic                ack_i,
	input  logic                err_i,
	input  arc_pkg::cpu_data_t  dat_i,
	input  logic                mem_cyc_i,
	input  logic                mem_stb_i,
	input  logic                mem_ack_i,
	input  logic                mem_we_i,
	input  logic [3:0]          mem_sel_i,
	input  arc_pkg::cpu_addr_t  mem_adr_i,
	input  arc_pkg::cpu_data_t  mem_dat_i,
	input  logic                kbd_strobe_i,
	input  arc_pkg::ioc_byte_t  kbd_data_i,
	input  logic                irq_i,
	input  logic                led_i,
	input  logic [arc_pkg::CTRL_W-1:0] ctrl_i
);

	int                 errors = 0;
	int                 checks = 0;
	// pending bus reply
	logic               reply_armed = 1'b0;
	string              reply_name;
	logic               exp_read;
	arc_pkg::cpu_data_t exp_dat;
	logic               exp_err;
	// pending memory transfer and whether it was seen
	logic               mem_armed = 1'b0;
	logic               mem_done = 1'b0;
	logic               exp_mem_we;
	arc_pkg::cpu_addr_t exp_mem_adr;
	logic [3:0]         exp_mem_sel;
	arc_pkg::cpu_data_t exp_mem_dat;
	// keyboard and irq history
	int                 kbd_count = 0;
	arc_pkg::ioc_byte_t kbd_last = '0;
	int                 irq_falls = 0;
	logic               irq_q = 1'b0;

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic expect_reply(input string name, input logic rd, input logic [31:0] dat,
			input logic err);
		reply_name  = name;
		exp_read    = rd;
		exp_dat     = dat;
		exp_err     = err;
		reply_armed = 1'b1;
	endtask

	task automatic expect_mem(input logic we, input arc_pkg::cpu_addr_t adr,
			input logic [3:0] sel, input arc_pkg::cpu_data_t dat);
		exp_mem_we  = we;
		exp_mem_adr = adr;
		exp_mem_sel = sel;
		exp_mem_dat = dat;
		mem_done    = 1'b0;
		mem_armed   = 1'b1;
	endtask

	task automatic clear_mem(input string name);
		if (mem_armed && !mem_done) begin
			report({name, " expected a memory transfer that never came"});
		end
		mem_armed = 1'b0;
	endtask

	task automatic check_state(input string name, input logic irq, input logic led);
		check_value({name, " irq"}, 32'(irq), 32'(irq_i));
		check_value({name, " led"}, 32'(led), 32'(led_i));
	endtask

	task automatic check_ctrl(input string name, input logic [arc_pkg::CTRL_W-1:0] ctrl);
		check_value({name, " ctrl"}, 32'(ctrl), 32'(ctrl_i));
	endtask

	// outputs are stable at the falling edge
	always @(negedge CLKCPU_I) begin
		if (ack_i && err_i) begin
			report("acknowledge and error high in the same cycle");
		end
		if (ack_i || err_i) begin
			if (!reply_armed) begin
				report("reply seen with no request pending");
			end else begin
				check_value({reply_name, " err"}, 32'(exp_err), 32'(err_i));
				if (exp_read && ack_i) begin
					check_value({reply_name, " rdata"}, exp_dat, dat_i);
				end
				reply_armed = 1'b0;
			end
		end
		if ((mem_stb_i || mem_cyc_i) && !mem_armed) begin
			report("memory cycle with no memory request pending");
		end
		if (mem_stb_i !== mem_cyc_i) begin
			report("memory cycle and memory strobe differ");
		end
		if (mem_stb_i && mem_ack_i && mem_armed) begin
			check_value({reply_name, " mem_adr"}, 32'(exp_mem_adr), 32'(mem_adr_i));
			check_value({reply_name, " mem_we"}, 32'(exp_mem_we), 32'(mem_we_i));
			if (exp_mem_we) begin
				check_value({reply_name, " mem_sel"}, 32'(exp_mem_sel), 32'(mem_sel_i));
				check_value({reply_name, " mem_dat"}, exp_mem_dat, mem_dat_i);
			end
			mem_done = 1'b1;
		end
		if (kbd_strobe_i) begin
			kbd_count++;
			kbd_last = kbd_data_i;
		end
		if (irq_q && !irq_i) begin
			irq_falls++;
		end
		irq_q = irq_i;
	end

endmodule

/* tb_arc_io.sv */
`timescale 1ns/1ns

module tb_arc_io;

	localparam int POR_CYCLES = 16;
	localparam int TIMEOUT    = 64;

	logic               CLKCPU_I = 1'b0;
	logic               rst_n_i;
	logic               cpu_cyc_i, cpu_stb_i, cpu_we_i;
	logic [3:0]         cpu_sel_i;
	arc_pkg::cpu_addr_t cpu_adr_i;
	arc_pkg::cpu_data_t cpu_dat_i, cpu_dat_o;
	logic               cpu_ack_o, cpu_err_o, cpu_irq_o;
	logic               mem_cyc_o, mem_stb_o, mem_we_o, mem_ack_i;
	logic [3:0]         mem_sel_o;
	arc_pkg::cpu_addr_t mem_adr_o;
	arc_pkg::cpu_data_t mem_dat_o, mem_dat_i;
	logic               flyback_i, kbd_out_strobe_o, kbd_in_strobe_i, debug_led_o;
	arc_pkg::ioc_byte_t kbd_out_data_o, kbd_in_data_i;
	logic [5:0]         ioc_ctrl_o;

	// memory model state
	logic [31:0]        lfsr_q = 32'h25c6;
	logic               mem_busy = 1'b0;
	logic [1:0]         mem_wait = '0;

	// expected control port, all ones out of reset
	logic [5:0]         ctrl_exp = 6'h3F;

	// operation table with one entry per index
	string       q_name[$];
	logic        q_we[$], q_err[$], q_kbd_en[$], q_fly[$], q_irq[$], q_led[$];
	logic [25:0] q_adr[$];
	logic [31:0] q_wdata[$], q_rdata[$];
	logic [7:0]  q_kbd_byte[$];

	always #4 CLKCPU_I = ~CLKCPU_I;

	arc_io_top #(.POR_CYCLES(POR_CYCLES)) dut_i (.*);

	tb_arc_checker chk_i (
		.CLKCPU_I(CLKCPU_I), .ack_i(cpu_ack_o), .err_i(cpu_err_o), .dat_i(cpu_dat_o),
		.mem_cyc_i(mem_cyc_o), .mem_stb_i(mem_stb_o), .mem_ack_i(mem_ack_i),
		.mem_we_i(mem_we_o), .mem_sel_i(mem_sel_o), .mem_adr_i(mem_adr_o),
		.mem_dat_i(mem_dat_o), .kbd_strobe_i(kbd_out_strobe_o), .kbd_data_i(kbd_out_data_o),
		.irq_i(cpu_irq_o), .led_i(debug_led_o), .ctrl_i(ioc_ctrl_o)
	);

	// galois lfsr stepped once per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [31:0] mem_rule(input logic [25:0] badr);
		return {8'h00, badr[25:2]} ^ 32'hA5A5_0000;
	endfunction

	function automatic logic is_mem(input logic [25:0] badr);
		return (badr < 26'h200_0000) || (badr >= 26'h380_0000);
	endfunction

	// memory answers after 0 to 3 wait cycles
	always @(posedge CLKCPU_I) begin
		if (mem_stb_o && !mem_ack_i) begin
			if (!mem_busy) begin
				mem_busy <= 1'b1;
				mem_wait <= {lfsr_bit(), lfsr_bit()};
			end else if (mem_wait == 2'd0) begin
				mem_busy  <= 1'b0;
				mem_ack_i <= 1'b1;
				mem_dat_i <= {8'h00, mem_adr_o} ^ 32'hA5A5_0000;
			end else begin
				mem_wait <= mem_wait - 2'd1;
			end
		end else begin
			mem_ack_i <= 1'b0;
		end
	end

	task automatic add_op(input string name, input logic we, input logic [25:0] adr,
			input logic [31:0] wdata, input logic [31:0] rdata, input logic err,
			input logic kbd_en, input logic [7:0] kbd_byte, input logic fly,
			input logic irq, input logic led);
		q_name.push_back(name);
		q_we.push_back(we);
		q_adr.push_back(adr);
		q_wdata.push_back(wdata);
		q_rdata.push_back(rdata);
		q_err.push_back(err);
		q_kbd_en.push_back(kbd_en);
		q_kbd_byte.push_back(kbd_byte);
		q_fly.push_back(fly);
		q_irq.push_back(irq);
		q_led.push_back(led);
	endtask

	task automatic fill_table();
		add_op("ram_rd", 0, 26'h000_1000, 0, mem_rule(26'h000_1000), 0, 0, 0, 0, 0, 1);
		add_op("ram_wr", 1, 26'h000_2000, 32'h1234_5678, 0, 0, 0, 0, 0, 0, 1);
		add_op("ram_rd_top", 0, 26'h1FF_FFFC, 0, mem_rule(26'h1FF_FFFC), 0, 0, 0, 0, 0, 1);
		add_op("rom_rd", 0, 26'h380_0040, 0, mem_rule(26'h380_0040), 0, 0, 0, 0, 0, 1);
		add_op("rom_rd_end", 0, 26'h3FF_FFFC, 0, mem_rule(26'h3FF_FFFC), 0, 0, 0, 0, 0, 1);
		add_op("rom_wr", 1, 26'h3A0_0100, 32'hCAFE_F00D, 0, 0, 0, 0, 0, 0, 1);
		add_op("unmapped_rd", 0, 26'h300_0000, 0, 0, 1, 0, 0, 0, 0, 1);
		add_op("unmapped_wr", 1, 26'h200_0000, 32'h0011_0000, 0, 1, 0, 0, 0, 0, 1);
		add_op("latch_off", 1, 26'h335_0040, 32'h0000_0000, 0, 0, 0, 0, 0, 0, 0);
		add_op("latch_rd0", 0, 26'h335_0040, 0, 32'h0000_0000, 0, 0, 0, 0, 0, 0);
		add_op("latch_on", 1, 26'h335_0040, 32'h0041_0000, 0, 0, 0, 0, 0, 0, 1);
		add_op("latch_rd1", 0, 26'h335_0040, 0, 32'h0000_0041, 0, 0, 0, 0, 0, 1);
		add_op("ctrl_wr", 1, 26'h320_0000, 32'h0015_0000, 0, 0, 0, 0, 0, 0, 1);
		add_op("ctrl_rd", 0, 26'h320_0000, 0, 32'h1515_1515, 0, 0, 0, 0, 0, 1);
		add_op("stat_reset", 0, 26'h320_0010, 0, 32'h4040_4040, 0, 0, 0, 0, 0, 1);
		add_op("mask_tx", 1, 26'h320_0018, 32'h0040_0000, 0, 0, 0, 0, 0, 1, 1);
		add_op("kbd_tx", 1, 26'h320_0004, 32'h005A_0000, 0, 0, 0, 0, 0, 1, 1);
		add_op("mask_rx_fly", 1, 26'h320_0018, 32'h0088_0000, 0, 0, 0, 0, 0, 0, 1);
		add_op("stat_events", 0, 26'h320_0010, 0, 32'hC8C8_C8C8, 0, 1, 8'hC3, 1, 1, 1);
		add_op("req_rd", 0, 26'h320_0014, 0, 32'h8888_8888, 0, 0, 0, 0, 1, 1);
		add_op("kbd_rd", 0, 26'h320_0004, 0, 32'hC3C3_C3C3, 0, 0, 0, 0, 1, 1);
		add_op("req_clr_fly", 1, 26'h320_0014, 32'h0008_0000, 0, 0, 0, 0, 0, 0, 1);
		add_op("stat_clear", 0, 26'h320_0010, 0, 32'h4040_4040, 0, 0, 0, 0, 0, 1);
		add_op("ram_rd_last", 0, 26'h0AB_CDE0, 0, mem_rule(26'h0AB_CDE0), 0, 0, 0, 0, 0, 1);
	endtask

	// counts falling edges up to the reply or gives -1 on timeout
	task automatic wait_reply(input string name, output int lat);
		int n;
		n = 0;
		lat = -1;
		while (n < TIMEOUT) begin
			@(negedge CLKCPU_I);
			n++;
			if (cpu_ack_o || cpu_err_o) begin
				lat = n - 1;
				break;
			end
		end
		if (lat < 0) chk_i.report({name, " timed out waiting for ack or err"});
	endtask

	task automatic drive_request(input logic we, input logic [25:0] badr,
			input logic [31:0] dat);
		@(posedge CLKCPU_I);
		cpu_cyc_i <= 1'b1;
		cpu_stb_i <= 1'b1;
		cpu_we_i  <= we;
		cpu_sel_i <= we ? 4'b0011 : 4'b1111;
		cpu_adr_i <= badr[25:2];
		cpu_dat_i <= dat;
	endtask

	task automatic release_bus();
		@(posedge CLKCPU_I);
		cpu_cyc_i <= 1'b0;
		cpu_stb_i <= 1'b0;
	endtask

	task automatic inject_events(input int i);
		if (q_kbd_en[i]) begin
			@(posedge CLKCPU_I);
			kbd_in_strobe_i <= 1'b1;
			kbd_in_data_i   <= q_kbd_byte[i];
			@(posedge CLKCPU_I);
			kbd_in_strobe_i <= 1'b0;
		end
		if (q_fly[i]) begin
			@(posedge CLKCPU_I);
			flyback_i <= 1'b1;
			repeat (2) @(posedge CLKCPU_I);
			flyback_i <= 1'b0;
		end
		repeat (2) @(posedge CLKCPU_I);
	endtask

	task automatic run_op(input int i);
		int lat;
		int kbd_before;
		int falls_before;
		int t;
		logic kbd_tx;
		inject_events(i);
		kbd_tx = q_we[i] && (q_adr[i] == 26'h320_0004);
		kbd_before = chk_i.kbd_count;
		falls_before = chk_i.irq_falls;
		chk_i.expect_reply(q_name[i], !q_we[i], q_rdata[i], q_err[i]);
		if (is_mem(q_adr[i])) begin
			chk_i.expect_mem(q_we[i], q_adr[i][25:2], 4'b0011, q_wdata[i]);
		end
		drive_request(q_we[i], q_adr[i], q_wdata[i]);
		wait_reply(q_name[i], lat);
		release_bus();
		if (!is_mem(q_adr[i]) && lat >= 0) begin
			chk_i.check_value({q_name[i], " latency"}, 32'd2, 32'(lat));
		end
		if (kbd_tx) begin
			t = 0;
			while (t < TIMEOUT && chk_i.kbd_count == kbd_before) begin
				@(negedge CLKCPU_I);
				t++;
			end
			if (t == TIMEOUT) chk_i.report({q_name[i], " timed out waiting for kbd strobe"});
		end
		repeat (3) @(posedge CLKCPU_I);
		chk_i.clear_mem(q_name[i]);
		@(negedge CLKCPU_I);
		chk_i.check_value({q_name[i], " kbd strobes"}, 32'(kbd_tx),
			32'(chk_i.kbd_count - kbd_before));
		if (kbd_tx) begin
			chk_i.check_value({q_name[i], " kbd byte"}, 32'(q_wdata[i][23:16]),
				32'(chk_i.kbd_last));
			// irq dips once while tx empty is low
			if (q_irq[i]) begin
				chk_i.check_value({q_name[i], " tx_empty dip"}, 32'd1,
					32'(chk_i.irq_falls - falls_before));
			end
		end
		chk_i.check_state(q_name[i], q_irq[i], q_led[i]);
		if (q_we[i] && (q_adr[i] == 26'h320_0000)) begin
			ctrl_exp = q_wdata[i][21:16];
		end
		chk_i.check_ctrl(q_name[i], ctrl_exp);
	endtask

	initial begin
		int lat;
		rst_n_i         = 1'b0;
		cpu_cyc_i       = 1'b0;
		cpu_stb_i       = 1'b0;
		cpu_we_i        = 1'b0;
		cpu_sel_i       = '0;
		cpu_adr_i       = '0;
		cpu_dat_i       = '0;
		mem_ack_i       = 1'b0;
		mem_dat_i       = '0;
		flyback_i       = 1'b0;
		kbd_in_strobe_i = 1'b0;
		kbd_in_data_i   = '0;
		fill_table();
		repeat (10) @(posedge CLKCPU_I);
		@(negedge CLKCPU_I);
		chk_i.check_state("reset", 1'b0, 1'b1);
		chk_i.check_ctrl("reset", ctrl_exp);
		// request raised at the raw reset release and held through the stretch
		chk_i.expect_reply("reset_hold", 1'b1, 32'h0000_00FF, 1'b0);
		@(posedge CLKCPU_I);
		rst_n_i <= 1'b1;
		cpu_cyc_i <= 1'b1;
		cpu_stb_i <= 1'b1;
		cpu_we_i  <= 1'b0;
		cpu_sel_i <= 4'b1111;
		cpu_adr_i <= arc_pkg::LATCHA_ADDR;
		wait_reply("reset_hold", lat);
		release_bus();
		if (lat >= 0 && lat <= POR_CYCLES + 2) begin
			chk_i.report("reply arrived while the stretched reset was still low");
		end
		chk_i.check_value("reset kbd strobes", 32'd0, 32'(chk_i.kbd_count));
		repeat (2) @(posedge CLKCPU_I);
		for (int i = 0; i < q_name.size(); i++) begin
			run_op(i);
		end
		repeat (4) @(posedge CLKCPU_I);
		$display("checks %0d errors %0d", chk_i.checks, chk_i.errors);
		if (chk_i.errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
arc_pkg.sv
arc_por.sv
arc_bus_ctrl.sv
arc_ioc.sv
arc_io_top.sv
tb_arc_checker.sv
tb_arc_io.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_arc_io -o sim_tb

# keep the log even when the simulation reports errors
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Result: PASSED" sim.log
